//--- logic/link_defines.svh
`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// word and lane geometry
`define LINK_WORD_W     32
`define LINK_NUM_LANES  4
// one byte per lane per frame
`define LINK_SLICE_W    (`LINK_WORD_W / `LINK_NUM_LANES)
// start + data + parity
`define LINK_FRAME_LEN  10

// queue depths, in words
`define LINK_TXQ_DEPTH  4
`define LINK_RXQ_DEPTH  4

// wishbone word addresses
`define LINK_ADDR_CTRL    2'd0
`define LINK_ADDR_STATUS  2'd1
`define LINK_ADDR_TX      2'd2
`define LINK_ADDR_RX      2'd3

`endif

//--- logic/link_pkg.sv
`default_nettype none

`include "link_defines.svh"

package link_pkg;

  // one data word as software sees it
  typedef logic [`LINK_WORD_W-1:0] word_t;

  // the byte carried by one lane in one frame
  typedef logic [`LINK_SLICE_W-1:0] slice_t;

  // receive queue entry
  // err is the OR of all lane parity errors for this word
  typedef struct packed {
    logic  err;
    word_t data;
  } rx_entry_t;

endpackage

`default_nettype wire

//--- logic/link_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module link_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 4
) (
  input  wire logic  clk_i,
  input  wire logic  reset_i,
  input  wire logic  push_i,
  input  wire item_t data_i,
  input  wire logic  pop_i,
  output item_t      data_o,
  output logic       full_o,
  output logic       empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry storage
  item_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic do_push;
  logic do_pop;

  // push on full and pop on empty are ignored
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  // head of queue is valid while not empty
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap at DEPTH, which need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count moves only when exactly one side acts
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/link_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module link_regs (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  // wishbone classic slave
  input  wire logic                   wb_cyc_i,
  input  wire logic                   wb_stb_i,
  input  wire logic                   wb_we_i,
  input  wire logic [1:0]             wb_adr_i,
  input  wire logic [`LINK_WORD_W-1:0] wb_dat_i,
  output logic [`LINK_WORD_W-1:0]     wb_dat_o,
  output logic                        wb_ack_o,
  // link control
  output logic                        enable_o,
  // transmit queue side
  output logic                        txq_push_o,
  output link_pkg::word_t             txq_data_o,
  input  wire logic                   txq_full_i,
  input  wire logic                   txq_empty_i,
  // receive queue side
  output logic                        rxq_pop_o,
  input  wire link_pkg::rx_entry_t    rxq_data_i,
  input  wire logic                   rxq_empty_i,
  // status inputs
  input  wire logic                   tx_busy_i,
  input  wire logic                   overflow_i
);

  logic req;
  logic accept;
  logic wr;
  logic rd;
  logic is_ctrl;
  logic is_status;
  logic is_tx;
  logic is_rx;

  logic enable_q;
  logic parity_err_q;
  logic overflow_q;

  logic [`LINK_WORD_W-1:0] rd_data;

  // new request only while no ack is out
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  assign is_ctrl   = (wb_adr_i == `LINK_ADDR_CTRL);
  assign is_status = (wb_adr_i == `LINK_ADDR_STATUS);
  assign is_tx     = (wb_adr_i == `LINK_ADDR_TX);
  assign is_rx     = (wb_adr_i == `LINK_ADDR_RX);

  // tx write waits here while the queue is full
  assign accept = req && !(wb_we_i && is_tx && txq_full_i);
  assign wr     = accept && wb_we_i;
  assign rd     = accept && !wb_we_i;

  assign txq_push_o = wr && is_tx;
  assign txq_data_o = wb_dat_i;
  // empty rx read still acks and returns zero
  assign rxq_pop_o  = rd && is_rx && !rxq_empty_i;

  assign enable_o = enable_q;

  // read mux
  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      `LINK_ADDR_CTRL: rd_data[0] = enable_q;
      `LINK_ADDR_STATUS: begin
        rd_data[0] = txq_empty_i;
        rd_data[1] = !rxq_empty_i;
        rd_data[2] = parity_err_q;
        rd_data[3] = overflow_q;
        rd_data[4] = tx_busy_i;
      end
      `LINK_ADDR_RX: rd_data = rxq_empty_i ? '0 : rxq_data_i.data;
      default: rd_data = '0;
    endcase
  end

  // single-cycle ack one cycle after accept
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= accept;
    end
  end

  // read data captured on accept
  always_ff @(posedge clk_i) begin
    if (rd) begin
      wb_dat_o <= rd_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q     <= 1'b0;
      parity_err_q <= 1'b0;
      overflow_q   <= 1'b0;
    end else begin
      if (wr && is_ctrl) begin
        enable_q <= wb_dat_i[0];
      end
      // write 1 clears unless a new event arrives in the same cycle
      if (wr && is_status && wb_dat_i[2]) begin
        parity_err_q <= 1'b0;
      end
      if (rxq_pop_o && rxq_data_i.err) begin
        parity_err_q <= 1'b1;
      end
      if (wr && is_status && wb_dat_i[3]) begin
        overflow_q <= 1'b0;
      end
      if (overflow_i) begin
        overflow_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/link_distributor.sv
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module link_distributor (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  input  wire logic                         enable_i,
  input  wire logic                         txq_empty_i,
  input  wire link_pkg::word_t              txq_data_i,
  output logic                              txq_pop_o,
  input  wire logic [`LINK_NUM_LANES-1:0]   lane_busy_i,
  output logic                              lane_load_o,
  output link_pkg::slice_t [`LINK_NUM_LANES-1:0] lane_slice_o,
  output logic                              tx_busy_o
);

  logic load_q;
  logic fire;

  link_pkg::slice_t [`LINK_NUM_LANES-1:0] slice_q;

  // pending load counts as busy, lanes only rise the cycle after it
  assign tx_busy_o = (|lane_busy_i) || load_q;

  // all lanes idle, a word waiting, link enabled
  assign fire      = enable_i && !txq_empty_i && !tx_busy_o;
  assign txq_pop_o = fire;

  assign lane_load_o  = load_q;
  assign lane_slice_o = slice_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      load_q <= 1'b0;
    end else begin
      // single-cycle strobe
      load_q <= fire;
    end
  end

  // lane 0 takes the low byte
  always_ff @(posedge clk_i) begin
    if (fire) begin
      for (int i = 0; i < `LINK_NUM_LANES; i++) begin
        slice_q[i] <= txq_data_i[i*`LINK_SLICE_W +: `LINK_SLICE_W];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/link_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module link_lane (
  input  wire logic             clk_i,
  input  wire logic             reset_i,
  // transmit side
  input  wire logic             load_i,
  input  wire link_pkg::slice_t slice_i,
  output logic                  busy_o,
  output logic                  ddr_o,
  // receive side
  input  wire logic             ddr_i,
  output logic                  rx_valid_o,
  output link_pkg::slice_t      rx_slice_o,
  output logic                  rx_parity_err_o
);

  localparam int CNT_W = $clog2(`LINK_FRAME_LEN + 1);

  logic [`LINK_FRAME_LEN-1:0] tx_frame_q;
  logic [CNT_W-1:0]           tx_cnt_q;

  logic [CNT_W-1:0]           rx_cnt_q;
  link_pkg::slice_t           rx_shift_q;

  // line shows bit 0 of the frame register
  assign ddr_o  = tx_frame_q[0];
  // high for exactly the frame length
  assign busy_o = (tx_cnt_q != '0);

  // transmit framer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_frame_q <= '0;
      tx_cnt_q   <= '0;
    end else if (load_i) begin
      // even parity on top, start bit at the bottom
      tx_frame_q <= {^slice_i, slice_i, 1'b1};
      tx_cnt_q   <= CNT_W'(`LINK_FRAME_LEN);
    end else if (busy_o) begin
      // zeros shift in, so the line idles low after parity
      tx_frame_q <= tx_frame_q >> 1;
      tx_cnt_q   <= tx_cnt_q - 1'b1;
    end
  end

  // receive counter
  // idle when zero, a high line then means start bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_cnt_q   <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (rx_cnt_q == '0) begin
        if (ddr_i) begin
          rx_cnt_q <= CNT_W'(`LINK_FRAME_LEN - 1);
        end
      end else begin
        rx_cnt_q <= rx_cnt_q - 1'b1;
        // last count is the parity bit
        if (rx_cnt_q == CNT_W'(1)) begin
          rx_valid_o <= 1'b1;
        end
      end
    end
  end

  // data path, lsb arrives first
  always_ff @(posedge clk_i) begin
    if (rx_cnt_q > CNT_W'(1)) begin
      rx_shift_q <= {ddr_i, rx_shift_q[`LINK_SLICE_W-1:1]};
    end
    if (rx_cnt_q == CNT_W'(1)) begin
      rx_slice_o      <= rx_shift_q;
      // nonzero means data and parity bit disagree
      rx_parity_err_o <= (^rx_shift_q) ^ ddr_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/link_collector.sv
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module link_collector (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,
  input  wire logic [`LINK_NUM_LANES-1:0]          lane_rx_valid_i,
  input  wire link_pkg::slice_t [`LINK_NUM_LANES-1:0] lane_rx_slice_i,
  input  wire logic [`LINK_NUM_LANES-1:0]          lane_rx_err_i,
  output logic                                     rxq_push_o,
  output link_pkg::rx_entry_t                      rxq_data_o,
  input  wire logic                                rxq_full_i,
  output logic                                     overflow_o
);

  // sticky per-lane arrival flags
  logic [`LINK_NUM_LANES-1:0] got_q;
  logic [`LINK_NUM_LANES-1:0] err_q;
  logic                       all_got;

  link_pkg::slice_t [`LINK_NUM_LANES-1:0] slice_q;

  assign all_got = &got_q;

  // push when the queue has room, else report the drop
  assign rxq_push_o = all_got && !rxq_full_i;
  assign overflow_o = all_got && rxq_full_i;

  // lane 0 lands in the low byte
  always_comb begin
    rxq_data_o.data = link_pkg::word_t'(slice_q);
    rxq_data_o.err  = |err_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      got_q <= '0;
    end else if (all_got) begin
      // word leaves now, keep any lane already reporting the next one
      got_q <= lane_rx_valid_i;
    end else begin
      got_q <= got_q | lane_rx_valid_i;
    end
  end

  // per-lane capture, lanes may be skewed
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `LINK_NUM_LANES; i++) begin
      if (lane_rx_valid_i[i]) begin
        slice_q[i] <= lane_rx_slice_i[i];
        err_q[i]   <= lane_rx_err_i[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/link_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module link_top (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  // wishbone classic slave
  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_we_i,
  input  wire logic [1:0]                  wb_adr_i,
  input  wire logic [`LINK_WORD_W-1:0]     wb_dat_i,
  output logic [`LINK_WORD_W-1:0]          wb_dat_o,
  output logic                             wb_ack_o,
  // serial lanes
  output logic [`LINK_NUM_LANES-1:0]       ddr_o,
  input  wire logic [`LINK_NUM_LANES-1:0]  ddr_i
);

  logic                enable;
  logic                tx_busy;
  logic                overflow;

  // transmit queue
  logic                txq_push;
  link_pkg::word_t     txq_wdata;
  link_pkg::word_t     txq_rdata;
  logic                txq_pop;
  logic                txq_full;
  logic                txq_empty;

  // receive queue
  logic                rxq_push;
  link_pkg::rx_entry_t rxq_wdata;
  link_pkg::rx_entry_t rxq_rdata;
  logic                rxq_pop;
  logic                rxq_full;
  logic                rxq_empty;

  // lane fan-out and fan-in
  logic                                   lane_load;
  link_pkg::slice_t [`LINK_NUM_LANES-1:0] lane_slice;
  logic [`LINK_NUM_LANES-1:0]             lane_busy;
  logic [`LINK_NUM_LANES-1:0]             lane_rx_valid;
  link_pkg::slice_t [`LINK_NUM_LANES-1:0] lane_rx_slice;
  logic [`LINK_NUM_LANES-1:0]             lane_rx_err;

  // bus-facing side
  link_regs i_regs (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .wb_cyc_i    ( wb_cyc_i  ),
    .wb_stb_i    ( wb_stb_i  ),
    .wb_we_i     ( wb_we_i   ),
    .wb_adr_i    ( wb_adr_i  ),
    .wb_dat_i    ( wb_dat_i  ),
    .wb_dat_o    ( wb_dat_o  ),
    .wb_ack_o    ( wb_ack_o  ),
    .enable_o    ( enable    ),
    .txq_push_o  ( txq_push  ),
    .txq_data_o  ( txq_wdata ),
    .txq_full_i  ( txq_full  ),
    .txq_empty_i ( txq_empty ),
    .rxq_pop_o   ( rxq_pop   ),
    .rxq_data_i  ( rxq_rdata ),
    .rxq_empty_i ( rxq_empty ),
    .tx_busy_i   ( tx_busy   ),
    .overflow_i  ( overflow  )
  );

  link_fifo #(
    .item_t ( link_pkg::word_t ),
    .DEPTH  ( `LINK_TXQ_DEPTH  )
  ) i_txq (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .push_i  ( txq_push  ),
    .data_i  ( txq_wdata ),
    .pop_i   ( txq_pop   ),
    .data_o  ( txq_rdata ),
    .full_o  ( txq_full  ),
    .empty_o ( txq_empty )
  );

  link_fifo #(
    .item_t ( link_pkg::rx_entry_t ),
    .DEPTH  ( `LINK_RXQ_DEPTH      )
  ) i_rxq (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .push_i  ( rxq_push  ),
    .data_i  ( rxq_wdata ),
    .pop_i   ( rxq_pop   ),
    .data_o  ( rxq_rdata ),
    .full_o  ( rxq_full  ),
    .empty_o ( rxq_empty )
  );

  // enable gates the link here
  link_distributor i_distributor (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .enable_i     ( enable     ),
    .txq_empty_i  ( txq_empty  ),
    .txq_data_i   ( txq_rdata  ),
    .txq_pop_o    ( txq_pop    ),
    .lane_busy_i  ( lane_busy  ),
    .lane_load_o  ( lane_load  ),
    .lane_slice_o ( lane_slice ),
    .tx_busy_o    ( tx_busy    )
  );

  for (genvar i = 0; i < `LINK_NUM_LANES; i++) begin : gen_lane
    link_lane i_lane (
      .clk_i           ( clk_i            ),
      .reset_i         ( reset_i          ),
      .load_i          ( lane_load        ),
      .slice_i         ( lane_slice[i]    ),
      .busy_o          ( lane_busy[i]     ),
      .ddr_o           ( ddr_o[i]         ),
      .ddr_i           ( ddr_i[i]         ),
      .rx_valid_o      ( lane_rx_valid[i] ),
      .rx_slice_o      ( lane_rx_slice[i] ),
      .rx_parity_err_o ( lane_rx_err[i]   )
    );
  end

  link_collector i_collector (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .lane_rx_valid_i ( lane_rx_valid ),
    .lane_rx_slice_i ( lane_rx_slice ),
    .lane_rx_err_i   ( lane_rx_err   ),
    .rxq_push_o      ( rxq_push      ),
    .rxq_data_o      ( rxq_wdata     ),
    .rxq_full_i      ( rxq_full      ),
    .overflow_o      ( overflow      )
  );

endmodule

`default_nettype wire

//--- dv/link_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "link_defines.svh"

module link_tb;

  // 100 ns clock
  localparam int HALF_PERIOD     = 50;
  localparam int BUS_WAIT_CYCLES = 100;
  localparam int POLL_LIMIT      = 100;
  // words sent over all tests
  localparam int NUM_WORDS       = 1 + 20 + 1 + `LINK_RXQ_DEPTH + 2;
  localparam int WATCHDOG_CYCLES = NUM_WORDS * 20 + 1500;

  logic                        clk_i;
  logic                        reset_i;
  logic                        wb_cyc_i;
  logic                        wb_stb_i;
  logic                        wb_we_i;
  logic [1:0]                  wb_adr_i;
  logic [`LINK_WORD_W-1:0]     wb_dat_i;
  logic [`LINK_WORD_W-1:0]     wb_dat_o;
  logic                        wb_ack_o;
  logic [`LINK_NUM_LANES-1:0]  ddr_o;
  logic [`LINK_NUM_LANES-1:0]  ddr_i;

  // flips a lane on the loopback wire
  logic [`LINK_NUM_LANES-1:0]  fault_mask;

  integer seed = 32'h646f;
  int     mismatch_count = 0;
  int     other_count = 0;
  int     rx_reads = 0;
  logic   exp_parity_sticky = 1'b0;

  // expected entries and words actually read from RX
  link_pkg::rx_entry_t     exp_q[$];
  logic [`LINK_WORD_W-1:0] seen_q[$];

  // external loopback
  assign ddr_i = ddr_o ^ fault_mask;

  link_top DUT (
    .clk_i    ( clk_i    ),
    .reset_i  ( reset_i  ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .ddr_o    ( ddr_o    ),
    .ddr_i    ( ddr_i    )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #HALF_PERIOD clk_i = ~clk_i;
    end
  end

  // expected word and parity outcome after the given data bits flip on the wire
  function automatic link_pkg::rx_entry_t predict_entry(
    input logic [`LINK_WORD_W-1:0] sent,
    input logic [`LINK_WORD_W-1:0] flips
  );
    link_pkg::rx_entry_t     entry;
    logic [`LINK_WORD_W-1:0] rx;
    logic                    tx_par;
    logic                    rx_par;
    rx        = sent ^ flips;
    entry.err = 1'b0;
    for (int l = 0; l < `LINK_NUM_LANES; l++) begin
      // parity bit travels clean while data may flip
      tx_par = ^sent[l*`LINK_SLICE_W +: `LINK_SLICE_W];
      rx_par = ^rx[l*`LINK_SLICE_W +: `LINK_SLICE_W];
      if (tx_par != rx_par) begin
        entry.err = 1'b1;
      end
    end
    entry.data = rx;
    return entry;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, expected);
      mismatch_count++;
    end
  endtask

  // wishbone classic write held until ack
  task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = data;
    @(negedge clk_i);
    while (!wb_ack_o && waited < BUS_WAIT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("%0t ns: no ack for a write to address %0d", $time, adr);
      other_count++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    @(negedge clk_i);
    while (!wb_ack_o && waited < BUS_WAIT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("%0t ns: no ack for a read of address %0d", $time, adr);
      other_count++;
    end
    // data is stable alongside ack
    data     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  // repeated STATUS reads until one bit reaches a value
  task automatic poll_status(input int bit_idx, input logic value, input string what);
    logic [31:0] status;
    int          tries;
    tries = 0;
    read_reg(`LINK_ADDR_STATUS, status);
    while (status[bit_idx] !== value && tries < POLL_LIMIT) begin
      read_reg(`LINK_ADDR_STATUS, status);
      tries++;
    end
    if (status[bit_idx] !== value) begin
      $display("%0t ns: gave up waiting for %s", $time, what);
      other_count++;
    end
  endtask

  // empties the RX queue into seen_q
  task automatic drain_rx();
    logic [31:0] status;
    logic [31:0] data;
    read_reg(`LINK_ADDR_STATUS, status);
    while (status[1]) begin
      read_reg(`LINK_ADDR_RX, data);
      seen_q.push_back(data);
      rx_reads++;
      read_reg(`LINK_ADDR_STATUS, status);
    end
  endtask

  // flip one data bit of the next frame on one lane
  task automatic inject_bit_flip(input int lane, input int bit_idx);
    int waited;
    waited = 0;
    @(negedge clk_i);
    // first high level on an idle lane is the start bit
    while (!ddr_o[lane] && waited < 50) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ddr_o[lane]) begin
      $display("%0t ns: lane %0d never started a frame", $time, lane);
      other_count++;
    end else begin
      repeat (bit_idx + 1) @(negedge clk_i);
      fault_mask[lane] = 1'b1;
      @(negedge clk_i);
      fault_mask[lane] = 1'b0;
    end
  endtask

  // compares every word read from RX with the model in order
  always @(posedge clk_i) begin : compare_rx
    link_pkg::rx_entry_t exp_entry;
    while (seen_q.size() > 0) begin
      if (exp_q.size() == 0) begin
        $display("%0t ns: a word came out of RX that was never expected", $time);
        other_count++;
        void'(seen_q.pop_front());
      end else begin
        exp_entry = exp_q.pop_front();
        check_value("rx word", seen_q.pop_front(), exp_entry.data);
        // sticky flag follows the popped entry
        if (exp_entry.err) begin
          exp_parity_sticky = 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]             data;
    logic [`LINK_WORD_W-1:0] word;
    int                      tries;
    // times print in whole ns
    $timeformat(-9, 0, "", 0);
    reset_i    = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    fault_mask = '0;
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;

    // reset values and CTRL readback
    check_value("wb_ack_o", 32'(wb_ack_o), 32'h0);
    check_value("ddr_o", 32'(ddr_o), 32'h0);
    read_reg(`LINK_ADDR_CTRL, data);
    check_value("ctrl", data, 32'h0);
    read_reg(`LINK_ADDR_STATUS, data);
    check_value("status", data, 32'h1);
    write_reg(`LINK_ADDR_CTRL, 32'h5);
    read_reg(`LINK_ADDR_CTRL, data);
    // only enable is stored
    check_value("ctrl", data, 32'h1);
    write_reg(`LINK_ADDR_CTRL, 32'h0);
    read_reg(`LINK_ADDR_CTRL, data);
    check_value("ctrl", data, 32'h0);

    // with the link off the word waits in the queue
    word = 32'hA5C3_0F81;
    exp_q.push_back(predict_entry(word, '0));
    write_reg(`LINK_ADDR_TX, word);
    repeat (40) begin
      @(negedge clk_i);
      check_value("ddr_o", 32'(ddr_o), 32'h0);
    end
    read_reg(`LINK_ADDR_STATUS, data);
    check_value("status", data, 32'h0);
    write_reg(`LINK_ADDR_CTRL, 32'h1);
    poll_status(1, 1'b1, "rx word after enable");
    drain_rx();

    // 20 random words with reads keeping pace with stalled writes
    rx_reads = 0;
    for (int i = 0; i < 20; i++) begin
      word = $random(seed);
      exp_q.push_back(predict_entry(word, '0));
      write_reg(`LINK_ADDR_TX, word);
      drain_rx();
    end
    tries = 0;
    while (rx_reads < 20 && tries < POLL_LIMIT) begin
      drain_rx();
      tries++;
    end
    if (rx_reads < 20) begin
      $display("%0t ns: only %0d of 20 random words came back", $time, rx_reads);
      other_count++;
    end
    read_reg(`LINK_ADDR_STATUS, data);
    check_value("status.parity_err", 32'(data[2]), 32'(exp_parity_sticky));

    // one data bit flipped on lane 2
    word = $random(seed);
    exp_q.push_back(predict_entry(word, 32'(1) << (2 * `LINK_SLICE_W + 5)));
    write_reg(`LINK_ADDR_TX, word);
    inject_bit_flip(2, 5);
    poll_status(1, 1'b1, "rx word with flipped bit");
    drain_rx();
    read_reg(`LINK_ADDR_STATUS, data);
    check_value("status.parity_err", 32'(data[2]), 32'(exp_parity_sticky));
    write_reg(`LINK_ADDR_STATUS, 32'h4);
    exp_parity_sticky = 1'b0;
    read_reg(`LINK_ADDR_STATUS, data);
    check_value("status.parity_err", 32'(data[2]), 32'h0);

    // only the first RXQ_DEPTH words survive the overflow
    write_reg(`LINK_ADDR_STATUS, 32'hC);
    for (int i = 0; i < `LINK_RXQ_DEPTH + 2; i++) begin
      word = $random(seed);
      if (i < `LINK_RXQ_DEPTH) begin
        exp_q.push_back(predict_entry(word, '0));
      end
      write_reg(`LINK_ADDR_TX, word);
    end
    poll_status(3, 1'b1, "overflow flag");
    poll_status(0, 1'b1, "transmit queue to empty");
    poll_status(4, 1'b0, "transmitter to go idle");
    // last dropped word clears the collector
    repeat (16) @(negedge clk_i);
    read_reg(`LINK_ADDR_STATUS, data);
    check_value("status.overflow", 32'(data[3]), 32'h1);
    for (int i = 0; i < `LINK_RXQ_DEPTH; i++) begin
      read_reg(`LINK_ADDR_RX, data);
      seen_q.push_back(data);
    end
    read_reg(`LINK_ADDR_STATUS, data);
    check_value("status.rx_not_empty", 32'(data[1]), 32'h0);
    read_reg(`LINK_ADDR_RX, data);
    check_value("rx empty read", data, 32'h0);

    repeat (4) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      $display("%0d expected words were never read back", exp_q.size());
      other_count++;
    end
    $display("errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
logic/link_pkg.sv
logic/link_fifo.sv
logic/link_regs.sv
logic/link_distributor.sv
logic/link_lane.sv
logic/link_collector.sv
logic/link_top.sv
dv/link_tb.sv

//--- Makefile
# Verilator build for the serial link testbench

VERILATOR ?= verilator
TOP       ?= link_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= TEST PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
